/* flist.f */
rtl/mm_pkg.sv
rtl/dma_read_path.sv
rtl/matrix_buffer.sv
rtl/mm_engine.sv
rtl/dma_write_path.sv
rtl/dma_engine.sv
rtl/mm_accel_top.sv
tests/mm_checker.sv
tests/tb_mm_accel.sv

/* rtl/dma_engine.sv */
`timescale 1ns/10ps
// ####################
// DMA control FSM that reads A and B, runs the engine,
// writes C back and pulses done
// ####################
module dma_engine (
    input  logic              clk,
    input  logic              rst_n,
    input  mm_pkg::addr_t     mat_a_addr_i,
    input  mm_pkg::addr_t     mat_b_addr_i,
    input  mm_pkg::addr_t     mat_c_addr_i,
    input  logic              start_i,
    output logic              done_o,
    output mm_pkg::ar_req_t   ar_o,
    input  logic              arready_i,
    input  mm_pkg::r_beat_t   r_i,
    output logic              rready_o,
    output mm_pkg::aw_req_t   aw_o,
    input  logic              awready_i,
    output mm_pkg::w_beat_t   w_o,
    input  logic              wready_i,
    input  mm_pkg::b_resp_t   b_i,
    output logic              bready_o,
    output mm_pkg::buf_wr_t   buf_a_wr_o,
    output mm_pkg::buf_wr_t   buf_b_wr_o,
    output logic              mm_start_o,
    input  logic              mm_done_i,
    input  mm_pkg::acc_mat_t  acc_i
);
    import mm_pkg::*;

    dma_state_e state_q;
    // latched on start so the inputs may move mid-run
    addr_t      a_addr_q;
    addr_t      b_addr_q;
    addr_t      c_addr_q;
    logic       rd_go;
    logic       rd_done;
    logic       wr_go;
    logic       wr_done;

    assign done_o = (state_q == FINISH);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q    <= IDLE;
            rd_go      <= 1'b0;
            wr_go      <= 1'b0;
            mm_start_o <= 1'b0;
        end else begin
            rd_go      <= 1'b0;
            wr_go      <= 1'b0;
            mm_start_o <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        a_addr_q <= mat_a_addr_i;
                        b_addr_q <= mat_b_addr_i;
                        c_addr_q <= mat_c_addr_i;
                        rd_go    <= 1'b1;
                        state_q  <= READ;
                    end
                end
                READ: begin
                    if (rd_done) begin
                        mm_start_o <= 1'b1;
                        state_q    <= COMPUTE;
                    end
                end
                COMPUTE: begin
                    if (mm_done_i) begin
                        wr_go   <= 1'b1;
                        state_q <= WRITE;
                    end
                end
                WRITE: begin
                    if (wr_done)
                        state_q <= FINISH;
                end
                FINISH:  state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    dma_read_path u_rd (
        .clk        (clk),
        .rst_n      (rst_n),
        .go_i       (rd_go),
        .a_addr_i   (a_addr_q),
        .b_addr_i   (b_addr_q),
        .ar_o       (ar_o),
        .arready_i  (arready_i),
        .r_i        (r_i),
        .rready_o   (rready_o),
        .buf_a_wr_o (buf_a_wr_o),
        .buf_b_wr_o (buf_b_wr_o),
        .done_o     (rd_done)
    );

    dma_write_path u_wr (
        .clk        (clk),
        .rst_n      (rst_n),
        .go_i       (wr_go),
        .c_addr_i   (c_addr_q),
        .acc_i      (acc_i),
        .aw_o       (aw_o),
        .awready_i  (awready_i),
        .w_o        (w_o),
        .wready_i   (wready_i),
        .b_i        (b_i),
        .bready_o   (bready_o),
        .done_o     (wr_done)
    );

    // each path reports done only in its own phase
    assert property (@(posedge clk) disable iff (!rst_n)
        rd_done |-> (state_q == READ));

    assert property (@(posedge clk) disable iff (!rst_n)
        wr_done |-> (state_q == WRITE));

    // engine finishes only while the FSM waits for it
    assert property (@(posedge clk) disable iff (!rst_n)
        mm_done_i |-> (state_q == COMPUTE));

endmodule

/* rtl/dma_read_path.sv */
`timescale 1ns/10ps
// ####################
// read side of the DMA: AR bursts for A then B, R beats
// sorted by id and packed four to a buffer line
// ####################
module dma_read_path (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            go_i,
    input  mm_pkg::addr_t   a_addr_i,
    input  mm_pkg::addr_t   b_addr_i,
    output mm_pkg::ar_req_t ar_o,
    input  logic            arready_i,
    input  mm_pkg::r_beat_t r_i,
    output logic            rready_o,
    output mm_pkg::buf_wr_t buf_a_wr_o,
    output mm_pkg::buf_wr_t buf_b_wr_o,
    output logic            done_o
);
    import mm_pkg::*;

    ar_req_t    ar_q;
    // per id: burst outstanding, last line written
    logic [1:0] pend_q;
    logic [1:0] fin_q;
    logic [3:0] cnt_q [2];
    line_t      line_q [2];
    buf_wr_t    wr_q [2];
    logic       ar_fire;
    logic       r_fire;

    assign ar_fire    = ar_q.valid && arready_i;
    assign r_fire     = r_i.valid && rready_o;
    assign rready_o   = |pend_q;
    assign ar_o       = ar_q;
    assign buf_a_wr_o = wr_q[ID_A];
    assign buf_b_wr_o = wr_q[ID_B];

    // A first, B the cycle after the A handshake
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ar_q.valid <= 1'b0;
        end else if (go_i) begin
            ar_q <= '{valid: 1'b1, id: ID_A, addr: a_addr_i};
        end else if (ar_fire) begin
            ar_q.valid <= (ar_q.id == ID_A);
            ar_q.id    <= ID_B;
            ar_q.addr  <= b_addr_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pend_q <= '0;
            fin_q  <= '0;
            done_o <= 1'b0;
            for (int m = 0; m < 2; m++) begin
                cnt_q[m]   <= '0;
                wr_q[m].en <= 1'b0;
            end
        end else begin
            done_o <= &fin_q;
            if (&fin_q)
                fin_q <= '0;
            if (ar_fire)
                pend_q[ar_q.id] <= 1'b1;
            for (int m = 0; m < 2; m++) begin
                wr_q[m].en <= 1'b0;
                if (r_fire && r_i.id == 1'(m)) begin
                    line_q[m][cnt_q[m][1:0]*ELEM_W +: ELEM_W] <= r_i.data;
                    cnt_q[m] <= cnt_q[m] + 4'd1;
                    // fourth element completes the row
                    if (cnt_q[m][1:0] == 2'd3) begin
                        wr_q[m].en   <= 1'b1;
                        wr_q[m].addr <= cnt_q[m][3:2];
                        wr_q[m].data <= {r_i.data, line_q[m][3*ELEM_W-1:0]};
                    end
                    if (cnt_q[m] == 4'(BEATS - 1)) begin
                        pend_q[m] <= 1'b0;
                        fin_q[m]  <= 1'b1;
                    end
                end
            end
        end
    end

    // rlast lines up with beat 15 of the same id
    assert property (@(posedge clk) disable iff (!rst_n)
        r_fire |-> (r_i.last == (cnt_q[r_i.id] == 4'(BEATS - 1))));

    // memory sends R only for a burst still in flight
    assert property (@(posedge clk) disable iff (!rst_n)
        r_i.valid |-> pend_q[r_i.id]);

endmodule

/* rtl/dma_write_path.sv */
`timescale 1ns/10ps
// ####################
// write side of the DMA: one AW, 16 W beats of C in
// row-major order, then the B response
// ####################
module dma_write_path (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             go_i,
    input  mm_pkg::addr_t    c_addr_i,
    input  mm_pkg::acc_mat_t acc_i,
    output mm_pkg::aw_req_t  aw_o,
    input  logic             awready_i,
    output mm_pkg::w_beat_t  w_o,
    input  logic             wready_i,
    input  mm_pkg::b_resp_t  b_i,
    output logic             bready_o,
    output logic             done_o
);
    import mm_pkg::*;

    wr_state_e  state_q;
    logic       awvalid_q;
    logic       wvalid_q;
    addr_t      awaddr_q;
    logic [3:0] beat_q;
    logic       w_fire;
    logic       b_fire;

    assign w_fire = wvalid_q && wready_i;
    assign b_fire = b_i.valid && bready_o;
    assign aw_o   = '{valid: awvalid_q, addr: awaddr_q};

    // low 32 bits of C[beat/4][beat%4]
    assign w_o = '{valid: wvalid_q,
                   data:  elem_t'(acc_i[beat_q[3:2]][beat_q[1:0]]),
                   last:  beat_q == 4'(BEATS - 1)};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q   <= AW;
            awvalid_q <= 1'b0;
            wvalid_q  <= 1'b0;
            bready_o  <= 1'b0;
            done_o    <= 1'b0;
            beat_q    <= '0;
        end else begin
            done_o <= 1'b0;
            case (state_q)
                AW: begin
                    if (go_i) begin
                        awvalid_q <= 1'b1;
                        awaddr_q  <= c_addr_i;
                    end else if (awvalid_q && awready_i) begin
                        awvalid_q <= 1'b0;
                        wvalid_q  <= 1'b1;
                        beat_q    <= '0;
                        state_q   <= W;
                    end
                end
                W: begin
                    if (w_fire) begin
                        beat_q <= beat_q + 4'd1;
                        if (beat_q == 4'(BEATS - 1)) begin
                            wvalid_q <= 1'b0;
                            bready_o <= 1'b1;
                            state_q  <= B;
                        end
                    end
                end
                B: begin
                    if (b_fire) begin
                        bready_o <= 1'b0;
                        done_o   <= 1'b1;
                        state_q  <= AW;
                    end
                end
                default: state_q <= AW;
            endcase
        end
    end

    // engine result must hold while beats are going out
    assert property (@(posedge clk) disable iff (!rst_n)
        wvalid_q |-> $stable(acc_i));

    // memory answers OKAY only
    assert property (@(posedge clk) disable iff (!rst_n)
        b_fire |-> (b_i.resp == 2'b00));

endmodule

/* rtl/matrix_buffer.sv */
`timescale 1ns/10ps
// ####################
// four-line matrix store, whole-line writes, registered read
// ####################
module matrix_buffer (
    input  logic               clk,
    input  mm_pkg::buf_wr_t    wr_i,
    input  mm_pkg::line_addr_t raddr_i,
    output mm_pkg::line_t      rdata_o
);
    import mm_pkg::*;

    line_t mem [MAT_N];

    always_ff @(posedge clk) begin
        if (wr_i.en)
            mem[wr_i.addr] <= wr_i.data;
        rdata_o <= mem[raddr_i];
    end

    // a new read address never meets a write to the same line
    assert property (@(posedge clk)
        (wr_i.en && wr_i.addr == raddr_i) |-> (raddr_i == $past(raddr_i)));

endmodule

/* rtl/mm_accel_top.sv */
`timescale 1ns/10ps
// ####################
// accelerator top: DMA engine, A/B line buffers and the
// multiply engine behind one set of AXI-style channels
// ####################
module mm_accel_top (
    input  logic            clk,
    input  logic            rst_n,
    input  mm_pkg::addr_t   mat_a_addr_i,
    input  mm_pkg::addr_t   mat_b_addr_i,
    input  mm_pkg::addr_t   mat_c_addr_i,
    input  logic            start_i,
    output logic            done_o,
    output mm_pkg::ar_req_t ar_o,
    input  logic            arready_i,
    input  mm_pkg::r_beat_t r_i,
    output logic            rready_o,
    output mm_pkg::aw_req_t aw_o,
    input  logic            awready_i,
    output mm_pkg::w_beat_t w_o,
    input  logic            wready_i,
    input  mm_pkg::b_resp_t b_i,
    output logic            bready_o
);
    import mm_pkg::*;

    buf_wr_t    buf_a_wr;
    buf_wr_t    buf_b_wr;
    line_addr_t a_raddr;
    line_addr_t b_raddr;
    line_t      a_line;
    line_t      b_line;
    acc_mat_t   acc;
    logic       mm_start;
    logic       mm_done;

    dma_engine u_dma (
        .clk          (clk),
        .rst_n        (rst_n),
        .mat_a_addr_i (mat_a_addr_i),
        .mat_b_addr_i (mat_b_addr_i),
        .mat_c_addr_i (mat_c_addr_i),
        .start_i      (start_i),
        .done_o       (done_o),
        .ar_o         (ar_o),
        .arready_i    (arready_i),
        .r_i          (r_i),
        .rready_o     (rready_o),
        .aw_o         (aw_o),
        .awready_i    (awready_i),
        .w_o          (w_o),
        .wready_i     (wready_i),
        .b_i          (b_i),
        .bready_o     (bready_o),
        .buf_a_wr_o   (buf_a_wr),
        .buf_b_wr_o   (buf_b_wr),
        .mm_start_o   (mm_start),
        .mm_done_i    (mm_done),
        .acc_i        (acc)
    );

    matrix_buffer u_buf_a (
        .clk     (clk),
        .wr_i    (buf_a_wr),
        .raddr_i (a_raddr),
        .rdata_o (a_line)
    );

    matrix_buffer u_buf_b (
        .clk     (clk),
        .wr_i    (buf_b_wr),
        .raddr_i (b_raddr),
        .rdata_o (b_line)
    );

    mm_engine u_mm (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_i   (mm_start),
        .a_raddr_o (a_raddr),
        .b_raddr_o (b_raddr),
        .a_line_i  (a_line),
        .b_line_i  (b_line),
        .acc_o     (acc),
        .done_o    (mm_done)
    );

endmodule

/* rtl/mm_engine.sv */
`timescale 1ns/10ps
// ####################
// 4x4 multiply engine: one (i,k) line pair per cycle,
// four signed MACs into the C accumulators
// ####################
module mm_engine (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start_i,
    output mm_pkg::line_addr_t a_raddr_o,
    output mm_pkg::line_addr_t b_raddr_o,
    input  mm_pkg::line_t      a_line_i,
    input  mm_pkg::line_t      b_line_i,
    output mm_pkg::acc_mat_t   acc_o,
    output logic               done_o
);
    import mm_pkg::*;

    logic       run_q;
    // step = {i, k}
    logic [3:0] step_q;
    logic       mac_q;
    logic [3:0] mac_step_q;
    acc_mat_t   acc_q;
    elem_t      a_ik;
    logic signed [2*ELEM_W-1:0] prod [MAT_N];

    assign a_raddr_o = step_q[3:2];
    assign b_raddr_o = step_q[1:0];
    assign acc_o     = acc_q;

    // A[i][k] times row k of B
    assign a_ik = a_line_i[mac_step_q[1:0]*ELEM_W +: ELEM_W];

    always_comb begin
        for (int j = 0; j < MAT_N; j++)
            prod[j] = a_ik * elem_t'(b_line_i[j*ELEM_W +: ELEM_W]);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run_q  <= 1'b0;
            step_q <= '0;
            mac_q  <= 1'b0;
            done_o <= 1'b0;
        end else begin
            mac_q  <= run_q;
            done_o <= mac_q && (mac_step_q == 4'(MAT_N * MAT_N - 1));
            if (start_i) begin
                run_q  <= 1'b1;
                step_q <= '0;
            end else if (run_q) begin
                step_q <= step_q + 4'd1;
                if (step_q == 4'(MAT_N * MAT_N - 1))
                    run_q <= 1'b0;
            end
        end
    end

    // buffer data lags the address by one cycle
    always_ff @(posedge clk) begin
        mac_step_q <= step_q;
        if (start_i) begin
            acc_q <= '0;
        end else if (mac_q) begin
            for (int j = 0; j < MAT_N; j++)
                acc_q[mac_step_q[3:2]][j] <= acc_q[mac_step_q[3:2]][j] + prod[j];
        end
    end

endmodule

/* rtl/mm_pkg.sv */
// ####################
// widths, types and AXI-style channel structs for the
// matrix-multiply accelerator, compiled ahead of all RTL
// ####################
package mm_pkg;

    localparam int ELEM_W  = 32;
    localparam int MAT_N   = 4;
    localparam int LINE_W  = MAT_N * ELEM_W;
    localparam int LINE_AW = 2;
    localparam int BEATS   = 16;
    localparam int ACC_W   = 2 * ELEM_W + 1;
    localparam logic ID_A  = 1'b0;
    localparam logic ID_B  = 1'b1;

    typedef logic        [31:0]        addr_t;
    typedef logic signed [ELEM_W-1:0]  elem_t;
    // element 0 sits in the low bits
    typedef logic        [LINE_W-1:0]  line_t;
    typedef logic        [LINE_AW-1:0] line_addr_t;
    typedef logic signed [ACC_W-1:0]   acc_t;
    typedef acc_t [MAT_N-1:0][MAT_N-1:0] acc_mat_t;

    typedef struct packed {
        logic  valid;
        logic  id;
        addr_t addr;
    } ar_req_t;

    typedef struct packed {
        logic  valid;
        logic  id;
        elem_t data;
        logic  last;
    } r_beat_t;

    typedef struct packed {
        logic  valid;
        addr_t addr;
    } aw_req_t;

    typedef struct packed {
        logic  valid;
        elem_t data;
        logic  last;
    } w_beat_t;

    typedef struct packed {
        logic       valid;
        logic [1:0] resp;
    } b_resp_t;

    typedef struct packed {
        logic       en;
        line_addr_t addr;
        line_t      data;
    } buf_wr_t;

    typedef enum logic [2:0] {IDLE, READ, COMPUTE, WRITE, FINISH} dma_state_e;
    typedef enum logic [1:0] {AW, W, B} wr_state_e;

endpackage

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_mm_accel \
    -f flist.f -Mdir obj_dir -o tb_mm_accel

./obj_dir/tb_mm_accel > sim.log 2>&1
cat sim.log

if grep -q -F '*** FAILED ***' sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if ! grep -q -F '*** PASSED ***' sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

/* tests/mm_checker.sv */
`timescale 1ns/10ps
// ####################
// watches AW, W, B and done_o, compares C with the expected
// values and prints one line per finished test
// ####################
module mm_checker (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              start_i,
    input  logic                              done_i,
    input  mm_pkg::aw_req_t                   aw_i,
    input  logic                              awready_i,
    input  mm_pkg::w_beat_t                   w_i,
    input  logic                              wready_i,
    input  mm_pkg::b_resp_t                   b_i,
    input  logic                              bready_i,
    input  logic [8*10-1:0]                   name_i,
    input  mm_pkg::addr_t                     exp_addr_i,
    input  mm_pkg::elem_t [mm_pkg::BEATS-1:0] exp_c_i,
    output int                                n_pass_o,
    output int                                n_fail_o
);
    import mm_pkg::*;

    logic armed;
    int   aw_n;
    int   w_n;
    int   b_n;
    int   errs;

    initial begin
        n_pass_o = 0;
        n_fail_o = 0;
        armed    = 1'b0;
        aw_n     = 0;
        w_n      = 0;
        b_n      = 0;
        errs     = 0;
        forever begin
            @(posedge clk);
            if (rst_n) begin
                if (start_i) begin
                    armed = 1'b1;
                    aw_n  = 0;
                    w_n   = 0;
                    b_n   = 0;
                    errs  = 0;
                end
                if (aw_i.valid && awready_i) begin
                    if (aw_i.addr != exp_addr_i) begin
                        $display("ERROR %s: AW address expected %h actual %h",
                                 name_i, exp_addr_i, aw_i.addr);
                        errs++;
                    end
                    aw_n++;
                end
                if (w_i.valid && wready_i) begin
                    if (aw_n == 0 || w_n >= BEATS) begin
                        $display("test %s: W beat %0d arrived outside the write burst",
                                 name_i, w_n);
                        errs++;
                    end else begin
                        if (w_i.data !== exp_c_i[w_n]) begin
                            $display("ERROR %s: C[%0d] expected %h actual %h",
                                     name_i, w_n, exp_c_i[w_n], w_i.data);
                            errs++;
                        end
                        if (w_i.last != (w_n == BEATS - 1)) begin
                            $display("ERROR %s: wlast on W beat %0d expected %0b actual %0b",
                                     name_i, w_n, (w_n == BEATS - 1), w_i.last);
                            errs++;
                        end
                    end
                    w_n++;
                end
                if (b_i.valid && bready_i)
                    b_n++;
                if (done_i) begin
                    if (!armed) begin
                        $display("done_o pulsed without a start before it");
                        n_fail_o++;
                    end else begin
                        if (aw_n != 1 || w_n != BEATS || b_n != 1) begin
                            $display("test %s: saw %0d AW, %0d W, %0d B instead of 1, %0d, 1",
                                     name_i, aw_n, w_n, b_n, BEATS);
                            errs++;
                        end
                        if (errs == 0) begin
                            $display("PASS %s", name_i);
                            n_pass_o++;
                        end else begin
                            $display("FAIL %s with %0d errors", name_i, errs);
                            n_fail_o++;
                        end
                        armed = 1'b0;
                    end
                end
            end
        end
    end

endmodule

/* tests/tb_mm_accel.sv */
`timescale 1ns/10ps
// ####################
// testbench for the matrix-multiply accelerator: clock, reset,
// AXI memory model with LFSR stalls and a table of runs
// ####################
module tb_mm_accel;
    import mm_pkg::*;

    localparam int          NUM_TESTS  = 6;
    localparam int          MEM_WORDS  = 1024;
    localparam int          DONE_LIMIT = 2000;
    localparam logic [31:0] SEED       = 32'hc4ca_bd02;

    typedef struct packed {
        logic [8*10-1:0] name;
        logic [1:0]      pat;
        addr_t           a_addr;
        addr_t           b_addr;
        addr_t           c_addr;
        logic            stall;
        logic            ilv;
    } test_t;

    logic    clk;
    logic    rst_n;
    addr_t   mat_a_addr;
    addr_t   mat_b_addr;
    addr_t   mat_c_addr;
    logic    start;
    logic    done;
    ar_req_t ar;
    logic    arready;
    r_beat_t r;
    logic    rready;
    aw_req_t aw;
    logic    awready;
    w_beat_t w;
    logic    wready;
    b_resp_t b;
    logic    bready;

    test_t             tbl [NUM_TESTS];
    elem_t             mem [MEM_WORDS];
    elem_t             a_m [BEATS];
    elem_t             b_m [BEATS];
    elem_t [BEATS-1:0] exp_c;
    logic [8*10-1:0]   cur_name;
    addr_t             exp_addr;
    logic              stall_en;
    logic              ilv_en;
    logic [31:0]       data_lfsr;
    logic [31:0]       stall_lfsr;
    int                n_pass;
    int                n_fail;
    logic              run_ok;
    logic              hang;

    // memory model state
    logic       rd_live [2];
    addr_t      rd_base [2];
    int         rd_beat [2];
    logic       last_sel;
    logic       b_due;
    logic       ar_hs;
    logic       r_hs;
    logic       w_hs;
    logic       b_hs;
    ar_req_t    ar_seen;
    logic       w_last_seen;

    mm_accel_top u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .mat_a_addr_i (mat_a_addr),
        .mat_b_addr_i (mat_b_addr),
        .mat_c_addr_i (mat_c_addr),
        .start_i      (start),
        .done_o       (done),
        .ar_o         (ar),
        .arready_i    (arready),
        .r_i          (r),
        .rready_o     (rready),
        .aw_o         (aw),
        .awready_i    (awready),
        .w_o          (w),
        .wready_i     (wready),
        .b_i          (b),
        .bready_o     (bready)
    );

    mm_checker u_chk (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_i    (start),
        .done_i     (done),
        .aw_i       (aw),
        .awready_i  (awready),
        .w_i        (w),
        .wready_i   (wready),
        .b_i        (b),
        .bready_i   (bready),
        .name_i     (cur_name),
        .exp_addr_i (exp_addr),
        .exp_c_i    (exp_c),
        .n_pass_o   (n_pass),
        .n_fail_o   (n_fail)
    );

    // Galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_word(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], data_lfsr[0]};
            data_lfsr = lfsr_next(data_lfsr);
        end
        return v;
    endfunction

    // two bits per draw, stall when both are set
    function automatic logic stall_bit();
        logic [1:0] bits;
        bits = '0;
        for (int i = 0; i < 2; i++) begin
            bits = {bits[0], stall_lfsr[0]};
            stall_lfsr = lfsr_next(stall_lfsr);
        end
        return stall_en && (&bits);
    endfunction

    // pattern 0: A identity, 1: random, 2: near the 32-bit limits
    function automatic elem_t pick_elem(input logic [1:0] pat, input int n, input logic is_a);
        logic [31:0] v;
        if (pat == 2'd0 && is_a) begin
            if (n / MAT_N == n % MAT_N)
                return 32'sd1;
            return 32'sd0;
        end
        if (pat == 2'd2) begin
            v = rand_word(2);
            case (v[1:0])
                2'd0:    return 32'sh7fff_ffff;
                2'd1:    return 32'sh8000_0000;
                2'd2:    return 32'sh8000_0001;
                default: return 32'sh7fff_fffe;
            endcase
        end
        return elem_t'(rand_word(32));
    endfunction

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // AXI slave, decides on the falling edge what the next rising edge sees
    initial begin : mem_model
        logic st_ar;
        logic st_r;
        logic st_aw;
        logic st_w;
        logic st_b;
        logic sel;
        int   widx;
        stall_lfsr = SEED;
        arready = 1'b0;
        awready = 1'b0;
        wready  = 1'b0;
        r       = '0;
        b       = '0;
        forever begin
            @(negedge clk);
            st_ar = stall_bit();
            st_r  = stall_bit();
            st_aw = stall_bit();
            st_w  = stall_bit();
            st_b  = stall_bit();
            if (!rst_n) begin
                arready  = 1'b0;
                awready  = 1'b0;
                wready   = 1'b0;
                r        = '0;
                b        = '0;
                rd_live  = '{1'b0, 1'b0};
                last_sel = ID_B;
                b_due    = 1'b0;
                ar_hs    = 1'b0;
                r_hs     = 1'b0;
                w_hs     = 1'b0;
                b_hs     = 1'b0;
            end else begin
                // transfers of the rising edge just past
                if (ar_hs) begin
                    rd_base[ar_seen.id] = ar_seen.addr;
                    rd_beat[ar_seen.id] = 0;
                    rd_live[ar_seen.id] = 1'b1;
                end
                if (r_hs) begin
                    rd_beat[r.id] = rd_beat[r.id] + 1;
                    if (rd_beat[r.id] == BEATS)
                        rd_live[r.id] = 1'b0;
                    last_sel = r.id;
                    r = '0;
                end
                if (w_hs && w_last_seen)
                    b_due = 1'b1;
                if (b_hs) begin
                    b     = '0;
                    b_due = 1'b0;
                end
                arready = !st_ar;
                awready = !st_aw;
                wready  = !st_w;
                if (!r.valid && (rd_live[ID_A] || rd_live[ID_B]) && !st_r) begin
                    if (rd_live[ID_A] && rd_live[ID_B])
                        sel = ilv_en ? !last_sel : ID_A;
                    else
                        sel = rd_live[ID_B];
                    widx = int'(rd_base[sel] >> 2) + rd_beat[sel];
                    r = '{valid: 1'b1, id: sel, data: mem[widx],
                          last: (rd_beat[sel] == BEATS - 1)};
                end
                if (b_due && !b.valid && !st_b)
                    b = '{valid: 1'b1, resp: 2'b00};
                ar_hs       = ar.valid && arready;
                ar_seen     = ar;
                r_hs        = r.valid && rready;
                w_hs        = w.valid && wready;
                w_last_seen = w.last;
                b_hs        = b.valid && bready;
            end
        end
    end

    task automatic run_test(input int t, output logic ok);
        int     cyc;
        longint sum;
        @(posedge clk);
        cur_name = tbl[t].name;
        exp_addr = tbl[t].c_addr;
        stall_en = tbl[t].stall;
        ilv_en   = tbl[t].ilv;
        for (int n = 0; n < BEATS; n++) begin
            a_m[n] = pick_elem(tbl[t].pat, n, 1'b1);
            b_m[n] = pick_elem(tbl[t].pat, n, 1'b0);
            mem[int'(tbl[t].a_addr >> 2) + n] = a_m[n];
            mem[int'(tbl[t].b_addr >> 2) + n] = b_m[n];
        end
        // row by column, low 32 bits of the exact sum
        for (int i = 0; i < MAT_N; i++) begin
            for (int j = 0; j < MAT_N; j++) begin
                sum = 0;
                for (int k = 0; k < MAT_N; k++)
                    sum += longint'(a_m[i*MAT_N+k]) * longint'(b_m[k*MAT_N+j]);
                exp_c[i*MAT_N+j] = elem_t'(sum[31:0]);
            end
        end
        @(negedge clk);
        mat_a_addr = tbl[t].a_addr;
        mat_b_addr = tbl[t].b_addr;
        mat_c_addr = tbl[t].c_addr;
        start      = 1'b1;
        @(negedge clk);
        start = 1'b0;
        // the DUT works from its latched copy
        mat_a_addr = ~tbl[t].a_addr;
        mat_b_addr = ~tbl[t].b_addr;
        mat_c_addr = ~tbl[t].c_addr;
        cyc = 0;
        while (!done && cyc < DONE_LIMIT) begin
            @(negedge clk);
            cyc++;
        end
        if (!done) begin
            $display("timeout: test %s got no done_o within %0d cycles", tbl[t].name, cyc);
            ok = 1'b0;
        end else begin
            cyc = 0;
            while (n_pass + n_fail < t + 1 && cyc < 8) begin
                @(negedge clk);
                cyc++;
            end
            ok = (n_pass + n_fail >= t + 1);
            if (!ok)
                $display("timeout: the checker gave no result for test %s", tbl[t].name);
        end
    endtask

    initial begin
        rst_n      = 1'b0;
        start      = 1'b0;
        mat_a_addr = '0;
        mat_b_addr = '0;
        mat_c_addr = '0;
        stall_en   = 1'b0;
        ilv_en     = 1'b0;
        cur_name   = '0;
        exp_addr   = '0;
        exp_c      = '0;
        hang       = 1'b0;
        data_lfsr  = SEED;
        for (int a = 0; a < MEM_WORDS; a++)
            mem[a] = elem_t'(32'h5a5a_0000 ^ (a * 32'h0001_0003));

        tbl[0] = '{name: "identity  ", pat: 2'd0, a_addr: 32'h000, b_addr: 32'h100,
                   c_addr: 32'h800, stall: 1'b0, ilv: 1'b0};
        tbl[1] = '{name: "random    ", pat: 2'd1, a_addr: 32'h040, b_addr: 32'h140,
                   c_addr: 32'h840, stall: 1'b0, ilv: 1'b0};
        tbl[2] = '{name: "stalls    ", pat: 2'd1, a_addr: 32'h080, b_addr: 32'h180,
                   c_addr: 32'h880, stall: 1'b1, ilv: 1'b0};
        tbl[3] = '{name: "interleave", pat: 2'd1, a_addr: 32'h0c0, b_addr: 32'h1c0,
                   c_addr: 32'h8c0, stall: 1'b0, ilv: 1'b1};
        tbl[4] = '{name: "stall_ilv ", pat: 2'd2, a_addr: 32'h200, b_addr: 32'h300,
                   c_addr: 32'h900, stall: 1'b1, ilv: 1'b1};
        tbl[5] = '{name: "back2back ", pat: 2'd1, a_addr: 32'h240, b_addr: 32'h340,
                   c_addr: 32'h940, stall: 1'b1, ilv: 1'b1};

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int t = 0; t < NUM_TESTS && !hang; t++) begin
            run_test(t, run_ok);
            hang = !run_ok;
        end
        // a stray done_o would show up here
        repeat (4) @(negedge clk);
        $display("tests run: %0d, passed: %0d, failed: %0d", NUM_TESTS, n_pass, n_fail);
        if (!hang && n_fail == 0 && n_pass == NUM_TESTS)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule
